// File: vlog.f
+incdir+logic
logic/asym_fifo_pkg.sv
logic/t2p_ram.sv
logic/t2p_asym_ram.sv
logic/fifo_level_ctrl.sv
logic/asym_fifo.sv
verification/asym_fifo_properties.sv
verification/asym_fifo_checker.sv
verification/asym_fifo_tb.sv

// File: Makefile
TOP = asym_fifo_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/asym_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "asym_fifo_defs.svh"

module asym_fifo_tb;

   localparam int N_ROWS      = 9;
   localparam int DRAIN_LIMIT = 200;

   // row modes
   localparam int SEQ  = 0;
   localparam int BOTH = 1;
   localparam int RAND = 2;

   logic                      r_clk;
   logic                      arst_n;
   logic                      w_en;
   asym_fifo_pkg::wide_word_u w_data;
   logic                      r_en;
   asym_fifo_pkg::byte_t      r_data;
   logic                      full;
   logic                      empty;
   asym_fifo_pkg::level_t     level;

   // stimulus table, for RAND rows the write count is a cycle count
   string row_name  [N_ROWS];
   int    row_wr    [N_ROWS];
   int    row_rd    [N_ROWS];
   int    row_mode  [N_ROWS];
   int    row_level [N_ROWS];
   logic  row_full  [N_ROWS];
   logic  row_empty [N_ROWS];

   int timeouts;
   int total_errors;

   asym_fifo UUT (
      .r_clk  (r_clk),
      .arst_n (arst_n),
      .w_en   (w_en),
      .w_data (w_data),
      .r_en   (r_en),
      .r_data (r_data),
      .full   (full),
      .empty  (empty),
      .level  (level)
   );

   asym_fifo_checker u_checker (
      .r_clk  (r_clk),
      .arst_n (arst_n),
      .w_en   (w_en),
      .w_data (w_data),
      .r_en   (r_en),
      .r_data (r_data),
      .full   (full),
      .empty  (empty),
      .level  (level)
   );

   initial begin
      r_clk = 1'b0;
      forever #2 r_clk = ~r_clk;
   end

   task automatic set_row(input int idx, input string name, input int n_wr, input int n_rd,
                          input int mode, input int lvl, input logic f, input logic e);
      row_name[idx]  = name;
      row_wr[idx]    = n_wr;
      row_rd[idx]    = n_rd;
      row_mode[idx]  = mode;
      row_level[idx] = lvl;
      row_full[idx]  = f;
      row_empty[idx] = e;
   endtask

   task automatic load_table();
      set_row(0, "after_reset",         0,   0,  SEQ,  0,  1'b0, 1'b1);
      set_row(1, "one_word",            1,   4,  SEQ,  0,  1'b0, 1'b1);
      // the 17th write hits a full FIFO
      set_row(2, "fill_past_full",      17,  0,  SEQ,  64, 1'b1, 1'b0);
      set_row(3, "drain_full",          0,   64, SEQ,  0,  1'b0, 1'b1);
      set_row(4, "read_empty",          0,   3,  SEQ,  0,  1'b0, 1'b1);
      set_row(5, "preload",             2,   0,  SEQ,  8,  1'b0, 1'b0);
      set_row(6, "write_read_together", 6,   6,  BOTH, 26, 1'b0, 1'b0);
      set_row(7, "drain_mixed",         0,   26, SEQ,  0,  1'b0, 1'b1);
      set_row(8, "random_mix",          200, 0,  RAND, 0,  1'b0, 1'b1);
   endtask

   // hold r_en until empty is seen at a falling edge
   task automatic drain_fifo();
      int cycles;
      cycles = 0;
      @(negedge r_clk);
      while (!empty && cycles < DRAIN_LIMIT) begin
         @(posedge r_clk);
         r_en <= 1'b1;
         @(negedge r_clk);
         cycles++;
      end
      @(posedge r_clk);
      r_en <= 1'b0;
      if (!empty) begin
         $display("the FIFO did not become empty within %0d read cycles", DRAIN_LIMIT);
         timeouts++;
      end
   endtask

   task automatic run_row(input int idx);
      int cycles;
      cycles = (row_wr[idx] > row_rd[idx]) ? row_wr[idx] : row_rd[idx];
      if (row_mode[idx] == BOTH) begin
         for (int i = 0; i < cycles; i++) begin
            @(posedge r_clk);
            w_en        <= (i < row_wr[idx]);
            r_en        <= (i < row_rd[idx]);
            w_data.word <= $urandom;
         end
      end else if (row_mode[idx] == RAND) begin
         // writes bring 4 bytes, so reads are made more likely
         for (int i = 0; i < row_wr[idx]; i++) begin
            @(posedge r_clk);
            w_en        <= (($urandom % 3) == 0);
            r_en        <= (($urandom % 4) != 0);
            w_data.word <= $urandom;
         end
      end else begin
         for (int i = 0; i < row_wr[idx]; i++) begin
            @(posedge r_clk);
            w_en        <= 1'b1;
            r_en        <= 1'b0;
            w_data.word <= $urandom;
         end
         for (int i = 0; i < row_rd[idx]; i++) begin
            @(posedge r_clk);
            w_en <= 1'b0;
            r_en <= 1'b1;
         end
      end
      @(posedge r_clk);
      w_en <= 1'b0;
      r_en <= 1'b0;
      if (row_mode[idx] == RAND) begin
         drain_fifo();
      end
      // one idle cycle lets the last read byte be compared
      @(posedge r_clk);
      @(negedge r_clk);
      u_checker.end_test(row_name[idx], row_level[idx], row_full[idx], row_empty[idx]);
   endtask

   initial begin
      void'($urandom(13809));
      timeouts    = 0;
      arst_n      = 1'b0;
      w_en        = 1'b0;
      r_en        = 1'b0;
      w_data.word = '0;
      load_table();
      repeat (3) @(posedge r_clk);
      arst_n <= 1'b1;
      for (int i = 0; i < N_ROWS; i++) begin
         run_row(i);
      end
      total_errors = u_checker.err_count + UUT.u_ctrl.u_props.fail_count + timeouts;
      $display("tests run: %0d, check errors: %0d, assertion failures: %0d, timeouts: %0d",
               u_checker.tests_run, u_checker.err_count, UUT.u_ctrl.u_props.fail_count,
               timeouts);
      if (total_errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/asym_fifo_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "asym_fifo_defs.svh"

module asym_fifo_checker (
   input wire logic                      r_clk,
   input wire logic                      arst_n,
   input wire logic                      w_en,
   input wire asym_fifo_pkg::wide_word_u w_data,
   input wire logic                      r_en,
   input wire asym_fifo_pkg::byte_t      r_data,
   input wire logic                      full,
   input wire logic                      empty,
   input wire asym_fifo_pkg::level_t     level
);

   localparam int DEPTH = 1 << `R_ADDR_W;

   // byte queue model, front is the next byte to read
   asym_fifo_pkg::byte_t byte_q [$];
   asym_fifo_pkg::byte_t exp_byte;
   logic                 have_byte;
   logic                 model_full;
   logic                 model_empty;

   int err_count  = 0;
   int test_errs  = 0;
   int tests_run  = 0;

   task automatic report_fail(input string msg);
      $display("Fail at time %0t: %s", $time, msg);
      err_count++;
      test_errs++;
   endtask

   always @(posedge r_clk or negedge arst_n) begin
      if (!arst_n) begin
         byte_q.delete();
         have_byte = 1'b0;
         exp_byte  = '0;
      end else begin
         model_empty = (byte_q.size() == 0);
         // full once a whole word no longer fits
         model_full  = ((DEPTH - byte_q.size()) < `LANES);
         if (level !== asym_fifo_pkg::level_t'(byte_q.size())) begin
            report_fail($sformatf("level is %0d, expected %0d", level, byte_q.size()));
         end
         if (full !== model_full) begin
            report_fail($sformatf("full is %b, expected %b", full, model_full));
         end
         if (empty !== model_empty) begin
            report_fail($sformatf("empty is %b, expected %b", empty, model_empty));
         end
         // also catches a byte that changes without an accepted read
         if (have_byte && r_data !== exp_byte) begin
            report_fail($sformatf("r_data is %h, expected %h", r_data, exp_byte));
         end
         if (r_en && !model_empty) begin
            exp_byte  = byte_q.pop_front();
            have_byte = 1'b1;
         end
         // least significant byte of the word goes out first
         if (w_en && !model_full) begin
            for (int i = 0; i < `LANES; i++) begin
               byte_q.push_back(w_data.word[i*`R_DATA_W +: `R_DATA_W]);
            end
         end
      end
   end

   task automatic end_test(input string name, input int exp_level, input logic exp_full,
                           input logic exp_empty);
      if (level !== asym_fifo_pkg::level_t'(exp_level)) begin
         report_fail($sformatf("%s ends with level %0d, expected %0d", name, level, exp_level));
      end
      if (full !== exp_full || empty !== exp_empty) begin
         report_fail($sformatf("%s ends with full %b empty %b, expected %b %b",
                               name, full, empty, exp_full, exp_empty));
      end
      if (test_errs == 0) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: %0d errors", name, test_errs);
      end
      test_errs = 0;
      tests_run++;
   endtask

endmodule

`default_nettype wire

// File: verification/asym_fifo_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "asym_fifo_defs.svh"

module asym_fifo_properties (
   input wire logic                  r_clk,
   input wire logic                  arst_n,
   input wire logic                  ram_w_en,
   input wire logic                  ram_r_en,
   input wire logic                  full,
   input wire logic                  empty,
   input wire asym_fifo_pkg::level_t level
);

   localparam int DEPTH = 1 << `R_ADDR_W;

   int fail_count = 0;

   a_flags_exclusive: assert property (@(posedge r_clk) disable iff (!arst_n)
      !(full && empty))
   else begin
      $error("full and empty are both high");
      fail_count++;
   end

   a_level_bound: assert property (@(posedge r_clk) disable iff (!arst_n)
      level <= DEPTH)
   else begin
      $error("level is above the FIFO depth");
      fail_count++;
   end

   // no accepted strobe, no level change
   a_level_hold: assert property (@(posedge r_clk) disable iff (!arst_n)
      (!ram_w_en && !ram_r_en) |=> $stable(level))
   else begin
      $error("level changed without an accepted strobe");
      fail_count++;
   end

endmodule

bind fifo_level_ctrl asym_fifo_properties u_props (
   .r_clk    (r_clk),
   .arst_n   (arst_n),
   .ram_w_en (ram_w_en),
   .ram_r_en (ram_r_en),
   .full     (full),
   .empty    (empty),
   .level    (level)
);

`default_nettype wire

// File: logic/asym_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "asym_fifo_defs.svh"

module asym_fifo (
   input  wire logic                      r_clk,
   input  wire logic                      arst_n,

   // write side, one 32-bit word per strobe
   input  wire logic                      w_en,
   input  wire asym_fifo_pkg::wide_word_u w_data,

   // read side, one byte per strobe, lowest lane first
   input  wire logic                      r_en,
   output asym_fifo_pkg::byte_t           r_data,

   // status
   output logic                           full,
   output logic                           empty,
   output asym_fifo_pkg::level_t          level
);

   logic                   ram_w_en;
   asym_fifo_pkg::w_addr_t ram_w_addr;
   logic                   ram_r_en;
   asym_fifo_pkg::r_addr_t ram_r_addr;

   // pointers, level and flags
   fifo_level_ctrl u_ctrl (
      .r_clk      (r_clk),
      .arst_n     (arst_n),
      .w_en       (w_en),
      .r_en       (r_en),
      .ram_w_en   (ram_w_en),
      .ram_w_addr (ram_w_addr),
      .ram_r_en   (ram_r_en),
      .ram_r_addr (ram_r_addr),
      .full       (full),
      .empty      (empty),
      .level      (level)
   );

   // storage, wide in and narrow out
   t2p_asym_ram #(
      .W_DATA_W (`W_DATA_W),
      .R_DATA_W (`R_DATA_W),
      .W_ADDR_W (`W_ADDR_W),
      .R_ADDR_W (`R_ADDR_W)
   ) u_ram (
      .r_clk  (r_clk),
      .w_en   (ram_w_en),
      .w_data (w_data),
      .w_addr (ram_w_addr),
      .r_en   (ram_r_en),
      .r_addr (ram_r_addr),
      .r_data (r_data)
   );

endmodule

`default_nettype wire

// File: logic/fifo_level_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "asym_fifo_defs.svh"

module fifo_level_ctrl (
   input  wire logic                   r_clk,
   input  wire logic                   arst_n,

   // strobes from the user side
   input  wire logic                   w_en,
   input  wire logic                   r_en,

   // towards the RAM
   output logic                        ram_w_en,
   output asym_fifo_pkg::w_addr_t      ram_w_addr,
   output logic                        ram_r_en,
   output asym_fifo_pkg::r_addr_t      ram_r_addr,

   // status
   output logic                        full,
   output logic                        empty,
   output asym_fifo_pkg::level_t       level
);

   // capacity in bytes
   localparam int DEPTH = 1 << `R_ADDR_W;

   // above this level a whole word no longer fits
   localparam asym_fifo_pkg::level_t FULL_AT = asym_fifo_pkg::level_t'(DEPTH - `LANES);

   localparam asym_fifo_pkg::level_t STEP_W  = asym_fifo_pkg::level_t'(`LANES);
   localparam asym_fifo_pkg::level_t STEP_WR = asym_fifo_pkg::level_t'(`LANES - 1);

   logic                   w_accept;
   logic                   r_accept;
   asym_fifo_pkg::w_addr_t w_ptr;
   asym_fifo_pkg::r_addr_t r_ptr;
   asym_fifo_pkg::level_t  level_q;
   asym_fifo_pkg::level_t  level_d;

   // a strobe against the flag is dropped
   assign w_accept = w_en & ~full;
   assign r_accept = r_en & ~empty;

   assign ram_w_en   = w_accept;
   assign ram_r_en   = r_accept;
   assign ram_w_addr = w_ptr;
   assign ram_r_addr = r_ptr;

   // word pointer, wraps at the end of the storage
   always_ff @(posedge r_clk or negedge arst_n) begin
      if (!arst_n) begin
         w_ptr <= '0;
      end else if (w_accept) begin
         w_ptr <= w_ptr + 1'b1;
      end
   end

   // byte pointer
   always_ff @(posedge r_clk or negedge arst_n) begin
      if (!arst_n) begin
         r_ptr <= '0;
      end else if (r_accept) begin
         r_ptr <= r_ptr + 1'b1;
      end
   end

   always_comb begin
      case ({w_accept, r_accept})
         2'b10:   level_d = level_q + STEP_W;
         2'b01:   level_d = level_q - 1'b1;
         2'b11:   level_d = level_q + STEP_WR;
         default: level_d = level_q;
      endcase
   end

   always_ff @(posedge r_clk or negedge arst_n) begin
      if (!arst_n) begin
         level_q <= '0;
      end else begin
         level_q <= level_d;
      end
   end

   // flags straight from the registered level
   assign full  = (level_q > FULL_AT);
   assign empty = (level_q == '0);
   assign level = level_q;

endmodule

`default_nettype wire

// File: logic/t2p_asym_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "asym_fifo_defs.svh"

module t2p_asym_ram #(
   parameter int W_DATA_W = `W_DATA_W,
   parameter int R_DATA_W = `R_DATA_W,
   parameter int W_ADDR_W = `W_ADDR_W,
   parameter int R_ADDR_W = `R_ADDR_W
) (
   input  wire logic                      r_clk,

   // wide write port
   input  wire logic                      w_en,
   input  wire asym_fifo_pkg::wide_word_u w_data,
   input  wire logic [W_ADDR_W-1:0]       w_addr,

   // narrow read port
   input  wire logic                      r_en,
   input  wire logic [R_ADDR_W-1:0]       r_addr,
   output logic      [R_DATA_W-1:0]       r_data
);

   // number of narrow blocks side by side
   localparam int N = W_DATA_W / R_DATA_W;

   // low byte-address bits pick the lane
   localparam int LSB_W = R_ADDR_W - W_ADDR_W;

   // write side, one lane per block
   logic [R_DATA_W-1:0] wr_lane [N];

   // read side
   logic [W_ADDR_W-1:0] rd_word_addr;
   logic [LSB_W-1:0]    rd_lane_addr;
   logic [LSB_W-1:0]    lane_sel_q;
   logic [R_DATA_W-1:0] rd_lane [N];

   // split the wide word into its byte lanes
   always_comb begin
      for (int i = 0; i < N; i++) begin
         wr_lane[i] = w_data.lane[i];
      end
   end

   // upper bits address the word, lower bits the lane inside it
   assign rd_word_addr = r_addr[R_ADDR_W-1 -: W_ADDR_W];
   assign rd_lane_addr = r_addr[LSB_W-1:0];

   for (genvar g = 0; g < N; g++) begin : g_lane_ram
      t2p_ram #(
         .DATA_W (R_DATA_W),
         .ADDR_W (W_ADDR_W)
      ) u_ram (
         .r_clk  (r_clk),
         .w_en   (w_en),
         .w_addr (w_addr),
         .w_data (wr_lane[g]),
         .r_en   (r_en),
         .r_addr (rd_word_addr),
         .r_data (rd_lane[g])
      );
   end

   // lane select lines up with the registered block outputs
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         lane_sel_q <= rd_lane_addr;
      end
   end

   // read mux
   always_comb begin
      r_data = rd_lane[lane_sel_q];
   end

endmodule

`default_nettype wire

// File: logic/t2p_ram.sv
`timescale 1ns/1ps
`default_nettype none

module t2p_ram #(
   parameter int DATA_W = 8,
   parameter int ADDR_W = 4
) (
   input  wire logic              r_clk,

   // write port
   input  wire logic              w_en,
   input  wire logic [ADDR_W-1:0] w_addr,
   input  wire logic [DATA_W-1:0] w_data,

   // read port
   input  wire logic              r_en,
   input  wire logic [ADDR_W-1:0] r_addr,
   output logic      [DATA_W-1:0] r_data
);

   localparam int DEPTH = 1 << ADDR_W;

   logic [DATA_W-1:0] mem [DEPTH];

   always_ff @(posedge r_clk) begin
      if (w_en) begin
         mem[w_addr] <= w_data;
      end
   end

   // output register only moves on a read, so the last byte is held
   always_ff @(posedge r_clk) begin
      if (r_en) begin
         r_data <= mem[r_addr];
      end
   end

endmodule

`default_nettype wire

// File: logic/asym_fifo_pkg.sv
`default_nettype none

`include "asym_fifo_defs.svh"

package asym_fifo_pkg;

   // same 32 bits, either as one vector or as byte lanes
   // lane 0 is the least significant byte
   typedef union packed {
      logic [`W_DATA_W-1:0]               word;
      logic [`LANES-1:0][`R_DATA_W-1:0]   lane;
   } wide_word_u;

   // fill level in bytes
   typedef logic [`LEVEL_W-1:0] level_t;

   // read side byte
   typedef logic [`R_DATA_W-1:0] byte_t;

   // pointers into the storage
   typedef logic [`W_ADDR_W-1:0] w_addr_t;
   typedef logic [`R_ADDR_W-1:0] r_addr_t;

endpackage

`default_nettype wire

// File: logic/asym_fifo_defs.svh
`ifndef ASYM_FIFO_DEFS_SVH
`define ASYM_FIFO_DEFS_SVH

// write side carries whole words, read side single bytes

// wide write word
`define W_DATA_W 32

// narrow read word
`define R_DATA_W 8

// byte address, 64 bytes of storage
`define R_ADDR_W 6

// word address, 16 words of storage
`define W_ADDR_W 4

// bytes per wide word
`define LANES 4

// one extra bit so a completely full FIFO is still representable
`define LEVEL_W (`R_ADDR_W + 1)

`endif
